//--- src.f
+incdir+common
common/iqPkg.sv
issueQueue/priorityEncoder.sv
issueQueue/issueQueue.sv
design/regFile.sv
design/execUnit.sv
design/issueCluster.sv
tb/issueCluster_props.sv
tb/issueCluster_tb.sv

//--- Bender.yml
package:
  name: issue_cluster

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/iqPkg.sv
      - issueQueue/priorityEncoder.sv
      - issueQueue/issueQueue.sv
      - design/regFile.sv
      - design/execUnit.sv
      - design/issueCluster.sv
      - target: test
        files:
          - tb/issueCluster_props.sv
          - tb/issueCluster_tb.sv

//--- tb/issueCluster_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "iq_cfg.svh"

module issueCluster_tb;

    localparam int NUM_OPS = 400;
    localparam int CHAIN_OPS = 16;
    localparam int CLK_PERIOD = 8;
    localparam int TAGS = 1 << `IQ_TAG_BITS;
    localparam int SQNS = 1 << `IQ_SQN_BITS;
    localparam int W = `IQ_DATA_BITS;
    localparam int SH_BITS = $clog2(W);

    logic          clk = 1'b0;
    logic          rst;
    logic          dispValid;
    logic          dispReady;
    iqPkg::aluOp_t dispOp;
    iqPkg::sqn_t   dispSqn;
    iqPkg::tag_t   dispTagDst;
    iqPkg::tag_t   dispTagA;
    iqPkg::opB_t   dispOpB;
    logic          dispImmB;
    logic          flush;
    iqPkg::sqn_t   flushSqn;
    logic          resValid;
    iqPkg::tag_t   resTagDst;
    iqPkg::sqn_t   resSqn;
    logic [W-1:0]  resValue;

    integer seed = 47240;

    // Reference model, register values in dispatch order
    logic [W-1:0]    modelVal [TAGS];
    logic [TAGS-1:0] dead;
    int              refCount [TAGS];

    // Ops in flight, indexed by sequence number
    logic [SQNS-1:0] inFlight;
    logic [W-1:0]    expVal [SQNS];
    iqPkg::tag_t     expTag [SQNS];
    iqPkg::tag_t     srcTagA [SQNS];
    iqPkg::tag_t     srcTagB [SQNS];
    logic [SQNS-1:0] srcRegB;

    iqPkg::sqn_t nextSqn;
    iqPkg::tag_t lastDst;
    int          opsMade;
    int          outstanding;
    int          flushCount;
    logic        accepted = 1'b0;
    logic        sawFull = 1'b0;

    always #(CLK_PERIOD / 2) clk = ~clk;

    issueCluster i_dut (
        .clk        (clk),
        .rst        (rst),
        .dispValid  (dispValid),
        .dispReady  (dispReady),
        .dispOp     (dispOp),
        .dispSqn    (dispSqn),
        .dispTagDst (dispTagDst),
        .dispTagA   (dispTagA),
        .dispOpB    (dispOpB),
        .dispImmB   (dispImmB),
        .flush      (flush),
        .flushSqn   (flushSqn),
        .resValid   (resValid),
        .resTagDst  (resTagDst),
        .resSqn     (resSqn),
        .resValue   (resValue)
    );

    // Handshake as seen at the edge
    always @(posedge clk) begin
        accepted <= dispValid && dispReady;
        if (dispValid && !dispReady && !flush)
            sawFull <= 1'b1;
    end

    function automatic logic [W-1:0] aluResult(iqPkg::aluOp_t op, logic [W-1:0] a,
                                                logic [W-1:0] b);
        case (op)
            iqPkg::OP_ADD: return a + b;
            iqPkg::OP_SUB: return a - b;
            iqPkg::OP_AND: return a & b;
            iqPkg::OP_XOR: return a ^ b;
            iqPkg::OP_SHL: return a << b[SH_BITS-1:0];
            default:       return a * b;
        endcase
    endfunction

    task automatic abortRun(string what);
        $display("error at %0t ns: %s", $time, what);
        $display("Test FAILED");
        $fatal(1);
    endtask

    task automatic reportMismatch(string name, logic [W-1:0] got, logic [W-1:0] want);
        abortRun($sformatf("%s is 0x%0h, expected 0x%0h", name, got, want));
    endtask

    task automatic releaseOp(int idx);
        inFlight[idx] = 1'b0;
        refCount[expTag[idx]] -= 1;
        refCount[srcTagA[idx]] -= 1;
        if (srcRegB[idx])
            refCount[srcTagB[idx]] -= 1;
        outstanding -= 1;
    endtask

    task automatic checkResult();
        int idx;
        idx = int'(resSqn);
        assert (inFlight[idx])
        else abortRun($sformatf("result for sequence number %0d was not expected", idx));
        assert (resTagDst == expTag[idx])
        else reportMismatch("resTagDst", W'(resTagDst), W'(expTag[idx]));
        assert (resValue == expVal[idx])
        else reportMismatch("resValue", resValue, expVal[idx]);
        releaseOp(idx);
    endtask

    // Younger means a positive wrapped difference to the pivot
    task automatic killYounger(iqPkg::sqn_t pivot);
        iqPkg::sqn_t diff;
        for (int i = 0; i < SQNS; i++) begin
            diff = iqPkg::sqn_t'(i) - pivot;
            if (inFlight[i] && !diff[`IQ_SQN_BITS-1] && diff != '0) begin
                dead[expTag[i]] = 1'b1;
                releaseOp(i);
            end
        end
    endtask

    // Prefer the last destination to build dependent chains
    task automatic pickSource(output iqPkg::tag_t t);
        logic [31:0] r;
        r = $random(seed);
        t = r[0] ? lastDst : iqPkg::tag_t'(r[15:8]);
        if (dead[t])
            t = '0;
    endtask

    task automatic makeOp();
        logic [31:0]  r;
        iqPkg::tag_t  dst;
        iqPkg::tag_t  a;
        iqPkg::tag_t  b;
        iqPkg::tag_t  t;
        logic         found;
        logic [W-1:0] bVal;
        r = $random(seed);
        found = 1'b0;
        dst = '0;
        // Destination needs no reader or writer in flight
        for (int k = 0; k < TAGS; k++) begin
            t = iqPkg::tag_t'(r[20:16] + k);
            if (!found && t != '0 && refCount[t] == 0) begin
                dst = t;
                found = 1'b1;
            end
        end
        if (!found)
            return;
        if (opsMade < CHAIN_OPS) begin
            // Multiply chain stalls the queue early on
            dispOp = (opsMade == 0) ? iqPkg::OP_ADD : iqPkg::OP_MUL;
            a = lastDst;
            dispImmB = 1'b1;
        end else begin
            dispOp = (r[7:5] > 3'd5) ? iqPkg::OP_MUL : iqPkg::aluOp_t'(r[7:5]);
            pickSource(a);
            dispImmB = r[8];
        end
        dispOpB.imm = $random(seed);
        b = '0;
        if (!dispImmB) begin
            pickSource(b);
            dispOpB.src.tag = b;
        end
        bVal = dispImmB ? dispOpB.imm : modelVal[b];
        expVal[nextSqn] = aluResult(dispOp, modelVal[a], bVal);
        expTag[nextSqn] = dst;
        srcTagA[nextSqn] = a;
        srcTagB[nextSqn] = b;
        srcRegB[nextSqn] = !dispImmB;
        inFlight[nextSqn] = 1'b1;
        refCount[dst] += 1;
        refCount[a] += 1;
        if (!dispImmB)
            refCount[b] += 1;
        modelVal[dst] = expVal[nextSqn];
        dead[dst] = 1'b0;
        dispSqn = nextSqn;
        dispTagDst = dst;
        dispTagA = a;
        dispValid = 1'b1;
        nextSqn = nextSqn + 1'b1;
        lastDst = dst;
        opsMade += 1;
        outstanding += 1;
    endtask

    initial begin
        #(NUM_OPS * 20 * CLK_PERIOD);
        abortRun("watchdog expired before the op stream completed");
    end

    initial begin
        rst = 1'b1;
        dispValid = 1'b0;
        dispOp = iqPkg::OP_ADD;
        dispSqn = '0;
        dispTagDst = '0;
        dispTagA = '0;
        dispOpB = '0;
        dispImmB = 1'b0;
        flush = 1'b0;
        flushSqn = '0;
        for (int i = 0; i < TAGS; i++) begin
            modelVal[i] = '0;
            refCount[i] = 0;
        end
        dead = '0;
        inFlight = '0;
        srcRegB = '0;
        nextSqn = '0;
        lastDst = '0;
        opsMade = 0;
        outstanding = 0;
        flushCount = 0;

        repeat (4) @(posedge clk);
        @(negedge clk);
        assert (!resValid && !i_dut.issValid && dispReady)
        else abortRun("cluster not idle and ready after reset");
        rst = 1'b0;

        while (opsMade < NUM_OPS || dispValid || outstanding > 0) begin
            @(negedge clk);
            flush = 1'b0;
            if (accepted)
                dispValid = 1'b0;
            if (resValid)
                checkResult();
            if (!dispValid && opsMade >= CHAIN_OPS && opsMade < NUM_OPS
                    && ($random(seed) & 31) == 0) begin
                flush = 1'b1;
                flushSqn = nextSqn - iqPkg::sqn_t'(1)
                    - iqPkg::sqn_t'($unsigned($random(seed)) % 5);
                killYounger(flushSqn);
                flushCount += 1;
            end else if (!dispValid && opsMade < NUM_OPS && ($random(seed) & 3) != 0) begin
                makeOp();
            end
        end

        if (!sawFull)
            abortRun("dispatch back-pressure never occurred");
        else if (flushCount == 0)
            abortRun("no flush was exercised");
        else begin
            $display("Test OK");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- tb/issueCluster_props.sv
`timescale 1ns/1ps
`default_nettype none

`include "iq_cfg.svh"

module issueCluster_props (
    input  wire                 clk,
    input  wire                 rst,
    input  wire                 dispValid,
    input  wire                 dispReady,
    input  wire iqPkg::aluOp_t  dispOp,
    input  wire iqPkg::sqn_t    dispSqn,
    input  wire iqPkg::tag_t    dispTagDst,
    input  wire iqPkg::tag_t    dispTagA,
    input  wire iqPkg::opB_t    dispOpB,
    input  wire                 dispImmB,
    input  wire                 flush,
    input  wire                 issValid,
    input  wire                 resValid,
    input  wire iqPkg::sqn_t    resSqn,
    input  wire                 aluDone,
    input  wire                 mulDone
);

    // Reset leaves the cluster idle and open for dispatch
    assert property (@(posedge clk) rst |=> !issValid && !resValid && (dispReady || flush))
    else $error("cluster not idle after reset");

    // A stalled dispatch keeps its payload until it is accepted
    assert property (@(posedge clk) disable iff (rst)
        dispValid && !dispReady |=> dispValid
            && $stable({dispOp, dispSqn, dispTagDst, dispTagA, dispOpB, dispImmB}))
    else $error("dispatch payload changed while stalled");

    // ALU and multiply results never meet on the bus
    assert property (@(posedge clk) disable iff (rst) !(aluDone && mulDone))
    else $error("ALU and multiply results collided");

    // One bus cycle per result
    assert property (@(posedge clk) disable iff (rst)
        resValid |=> !(resValid && resSqn == $past(resSqn)))
    else $error("sequence number repeated on the result bus");

endmodule

bind issueCluster issueCluster_props i_props (
    .clk        (clk),
    .rst        (rst),
    .dispValid  (dispValid),
    .dispReady  (dispReady),
    .dispOp     (dispOp),
    .dispSqn    (dispSqn),
    .dispTagDst (dispTagDst),
    .dispTagA   (dispTagA),
    .dispOpB    (dispOpB),
    .dispImmB   (dispImmB),
    .flush      (flush),
    .issValid   (issValid),
    .resValid   (resValid),
    .resSqn     (resSqn),
    .aluDone    (i_execUnit.aluValid),
    .mulDone    (i_execUnit.mulValid[`IQ_MUL_LAT-1])
);

`default_nettype wire

//--- design/issueCluster.sv
`timescale 1ns/1ps
`default_nettype none

`include "iq_cfg.svh"

module issueCluster (
    input  wire                          clk,
    input  wire                          rst,

    input  wire                          dispValid,
    output logic                         dispReady,
    input  wire iqPkg::aluOp_t           dispOp,
    input  wire iqPkg::sqn_t             dispSqn,
    input  wire iqPkg::tag_t             dispTagDst,
    input  wire iqPkg::tag_t             dispTagA,
    input  wire iqPkg::opB_t             dispOpB,
    input  wire                          dispImmB,

    input  wire                          flush,
    input  wire iqPkg::sqn_t             flushSqn,

    output logic                         resValid,
    output iqPkg::tag_t                  resTagDst,
    output iqPkg::sqn_t                  resSqn,
    output logic [`IQ_DATA_BITS-1:0]     resValue
);

    // Dispatch lookup
    iqPkg::tag_t lookupTagA;
    iqPkg::tag_t lookupTagB;
    logic        readyA;
    logic        readyB;

    // Issue to execute
    logic          issValid;
    iqPkg::aluOp_t issOp;
    iqPkg::sqn_t   issSqn;
    iqPkg::tag_t   issTagDst;
    iqPkg::tag_t   issTagA;
    iqPkg::opB_t   issOpB;
    logic          issImmB;

    // Operand reads
    iqPkg::tag_t              rdTagA;
    iqPkg::tag_t              rdTagB;
    logic [`IQ_DATA_BITS-1:0] rdValA;
    logic [`IQ_DATA_BITS-1:0] rdValB;

    // Destination is allocated on the dispatch handshake
    wire allocValid = dispValid && dispReady;

    issueQueue i_issueQueue (
        .clk        (clk),
        .rst        (rst),
        .dispValid  (dispValid),
        .dispReady  (dispReady),
        .dispOp     (dispOp),
        .dispSqn    (dispSqn),
        .dispTagDst (dispTagDst),
        .dispTagA   (dispTagA),
        .dispOpB    (dispOpB),
        .dispImmB   (dispImmB),
        .lookupTagA (lookupTagA),
        .lookupTagB (lookupTagB),
        .readyA     (readyA),
        .readyB     (readyB),
        .resValid   (resValid),
        .resTagDst  (resTagDst),
        .flush      (flush),
        .flushSqn   (flushSqn),
        .issValid   (issValid),
        .issOp      (issOp),
        .issSqn     (issSqn),
        .issTagDst  (issTagDst),
        .issTagA    (issTagA),
        .issOpB     (issOpB),
        .issImmB    (issImmB)
    );

    regFile i_regFile (
        .clk        (clk),
        .rst        (rst),
        .lookupTagA (lookupTagA),
        .lookupTagB (lookupTagB),
        .readyA     (readyA),
        .readyB     (readyB),
        .allocValid (allocValid),
        .allocTag   (dispTagDst),
        .rdTagA     (rdTagA),
        .rdTagB     (rdTagB),
        .rdValA     (rdValA),
        .rdValB     (rdValB),
        .resValid   (resValid),
        .resTagDst  (resTagDst),
        .resValue   (resValue)
    );

    execUnit i_execUnit (
        .clk       (clk),
        .rst       (rst),
        .issValid  (issValid),
        .issOp     (issOp),
        .issSqn    (issSqn),
        .issTagDst (issTagDst),
        .issTagA   (issTagA),
        .issOpB    (issOpB),
        .issImmB   (issImmB),
        .rdTagA    (rdTagA),
        .rdTagB    (rdTagB),
        .rdValA    (rdValA),
        .rdValB    (rdValB),
        .flush     (flush),
        .flushSqn  (flushSqn),
        .resValid  (resValid),
        .resTagDst (resTagDst),
        .resSqn    (resSqn),
        .resValue  (resValue)
    );

endmodule

`default_nettype wire

//--- design/execUnit.sv
`timescale 1ns/1ps
`default_nettype none

`include "iq_cfg.svh"

module execUnit (
    input  wire                          clk,
    input  wire                          rst,

    input  wire                          issValid,
    input  wire iqPkg::aluOp_t           issOp,
    input  wire iqPkg::sqn_t             issSqn,
    input  wire iqPkg::tag_t             issTagDst,
    input  wire iqPkg::tag_t             issTagA,
    input  wire iqPkg::opB_t             issOpB,
    input  wire                          issImmB,

    output iqPkg::tag_t                  rdTagA,
    output iqPkg::tag_t                  rdTagB,
    input  wire [`IQ_DATA_BITS-1:0]      rdValA,
    input  wire [`IQ_DATA_BITS-1:0]      rdValB,

    input  wire                          flush,
    input  wire iqPkg::sqn_t             flushSqn,

    output logic                         resValid,
    output iqPkg::tag_t                  resTagDst,
    output iqPkg::sqn_t                  resSqn,
    output logic [`IQ_DATA_BITS-1:0]     resValue
);

    localparam int LAT = `IQ_MUL_LAT;
    localparam int SH_BITS = $clog2(`IQ_DATA_BITS);

    logic [`IQ_DATA_BITS-1:0] opA;
    logic [`IQ_DATA_BITS-1:0] opB;
    logic [`IQ_DATA_BITS-1:0] aluOut;
    logic                     issueKeep;

    // ALU result stage
    logic                     aluValid;
    iqPkg::tag_t              aluTag;
    iqPkg::sqn_t              aluSqn;
    logic [`IQ_DATA_BITS-1:0] aluValue;

    // Multiply pipe, last stage drives the bus
    logic [LAT-1:0]           mulValid;
    iqPkg::tag_t              mulTag [LAT];
    iqPkg::sqn_t              mulSqn [LAT];
    logic [`IQ_DATA_BITS-1:0] mulValue [LAT];

    assign rdTagA = issTagA;
    assign rdTagB = issOpB.src.tag;

    assign opA = rdValA;
    assign opB = issImmB ? issOpB.imm : rdValB;

    // An op issued in the flush cycle dies here if it is younger
    assign issueKeep = issValid && !(flush && iqPkg::isYounger(issSqn, flushSqn));

    always_comb begin
        case (issOp)
            iqPkg::OP_ADD: aluOut = opA + opB;
            iqPkg::OP_SUB: aluOut = opA - opB;
            iqPkg::OP_AND: aluOut = opA & opB;
            iqPkg::OP_XOR: aluOut = opA ^ opB;
            iqPkg::OP_SHL: aluOut = opA << opB[SH_BITS-1:0];
            default:       aluOut = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            aluValid <= 1'b0;
            mulValid <= '0;
        end else begin
            aluValid <= issueKeep && issOp != iqPkg::OP_MUL;
            mulValid[0] <= issueKeep && issOp == iqPkg::OP_MUL;
            for (int s = 1; s < LAT; s++)
                mulValid[s] <= mulValid[s-1]
                    && !(flush && iqPkg::isYounger(mulSqn[s-1], flushSqn));
        end
    end

    always_ff @(posedge clk) begin
        aluTag <= issTagDst;
        aluSqn <= issSqn;
        aluValue <= aluOut;

        mulTag[0] <= issTagDst;
        mulSqn[0] <= issSqn;
        mulValue[0] <= opA * opB;
        for (int s = 1; s < LAT; s++) begin
            mulTag[s] <= mulTag[s-1];
            mulSqn[s] <= mulSqn[s-1];
            mulValue[s] <= mulValue[s-1];
        end
    end

    // The queue keeps both sources from landing in the same cycle
    assign resValid = aluValid || mulValid[LAT-1];
    assign resTagDst = aluValid ? aluTag : mulTag[LAT-1];
    assign resSqn = aluValid ? aluSqn : mulSqn[LAT-1];
    assign resValue = aluValid ? aluValue : mulValue[LAT-1];

endmodule

`default_nettype wire

//--- design/regFile.sv
`timescale 1ns/1ps
`default_nettype none

`include "iq_cfg.svh"

module regFile (
    input  wire                          clk,
    input  wire                          rst,

    input  wire iqPkg::tag_t             lookupTagA,
    input  wire iqPkg::tag_t             lookupTagB,
    output logic                         readyA,
    output logic                         readyB,

    input  wire                          allocValid,
    input  wire iqPkg::tag_t             allocTag,

    input  wire iqPkg::tag_t             rdTagA,
    input  wire iqPkg::tag_t             rdTagB,
    output logic [`IQ_DATA_BITS-1:0]     rdValA,
    output logic [`IQ_DATA_BITS-1:0]     rdValB,

    input  wire                          resValid,
    input  wire iqPkg::tag_t             resTagDst,
    input  wire [`IQ_DATA_BITS-1:0]      resValue
);

    localparam int REGS = 1 << `IQ_TAG_BITS;

    logic [`IQ_DATA_BITS-1:0] value [REGS];
    logic [REGS-1:0]          ready;

    // Tag 0 is never allocated, so its ready bit stays set
    assign readyA = ready[lookupTagA];
    assign readyB = ready[lookupTagB];

    assign rdValA = (rdTagA == '0) ? '0 : value[rdTagA];
    assign rdValB = (rdTagB == '0) ? '0 : value[rdTagB];

    always_ff @(posedge clk) begin
        if (rst) begin
            ready <= '1;
            // All registers come out of reset ready, so they hold zero
            for (int i = 0; i < REGS; i++)
                value[i] <= '0;
        end else begin
            if (resValid && resTagDst != '0) begin
                ready[resTagDst] <= 1'b1;
                value[resTagDst] <= resValue;
            end
            // New producer wins over a stale result for the same tag
            if (allocValid && allocTag != '0)
                ready[allocTag] <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- issueQueue/issueQueue.sv
`timescale 1ns/1ps
`default_nettype none

`include "iq_cfg.svh"

module issueQueue (
    input  wire                 clk,
    input  wire                 rst,

    input  wire                 dispValid,
    output logic                dispReady,
    input  wire iqPkg::aluOp_t  dispOp,
    input  wire iqPkg::sqn_t    dispSqn,
    input  wire iqPkg::tag_t    dispTagDst,
    input  wire iqPkg::tag_t    dispTagA,
    input  wire iqPkg::opB_t    dispOpB,
    input  wire                 dispImmB,

    output iqPkg::tag_t         lookupTagA,
    output iqPkg::tag_t         lookupTagB,
    input  wire                 readyA,
    input  wire                 readyB,

    input  wire                 resValid,
    input  wire iqPkg::tag_t    resTagDst,

    input  wire                 flush,
    input  wire iqPkg::sqn_t    flushSqn,

    output logic                issValid,
    output iqPkg::aluOp_t       issOp,
    output iqPkg::sqn_t         issSqn,
    output iqPkg::tag_t         issTagDst,
    output iqPkg::tag_t         issTagA,
    output iqPkg::opB_t         issOpB,
    output logic                issImmB
);

    localparam int SIZE = `IQ_SIZE;
    localparam int IDX_BITS = $clog2(SIZE);
    // ALU selections that would land on a multiply result
    localparam int RSV_BITS = `IQ_MUL_LAT - 1;
    localparam logic [RSV_BITS-1:0] MUL_SLOT = RSV_BITS'(1) << (RSV_BITS - 1);

    // Entry storage, index 0 is the oldest
    iqPkg::aluOp_t qOp [SIZE];
    iqPkg::sqn_t   qSqn [SIZE];
    iqPkg::tag_t   qTagDst [SIZE];
    iqPkg::tag_t   qTagA [SIZE];
    iqPkg::opB_t   qOpB [SIZE];
    logic [SIZE-1:0] qImmB;
    logic [SIZE-1:0] qAvailA;
    logic [SIZE-1:0] qAvailB;

    logic [IDX_BITS:0]   insertIndex;
    logic [IDX_BITS:0]   flushIndex;
    logic [RSV_BITS-1:0] reservedWb;

    logic [SIZE-1:0]     wakeA;
    logic [SIZE-1:0]     wakeB;
    logic [SIZE-1:0]     candidate;
    logic [IDX_BITS-1:0] selIdx;
    logic                selFound;

    logic enqValid;
    logic enqAvailA;
    logic enqAvailB;

    assign dispReady = (insertIndex != (IDX_BITS + 1)'(SIZE)) && !flush;
    assign enqValid = dispValid && dispReady;

    assign lookupTagA = dispTagA;
    assign lookupTagB = dispOpB.src.tag;

    // A source on the result bus this cycle counts as ready on entry
    assign enqAvailA = readyA || (resValid && resTagDst == dispTagA);
    assign enqAvailB = dispImmB || readyB || (resValid && resTagDst == dispOpB.src.tag);

    // Wakeup and ready check per entry
    always_comb begin
        for (int i = 0; i < SIZE; i++) begin
            wakeA[i] = resValid && resTagDst == qTagA[i];
            wakeB[i] = resValid && !qImmB[i] && resTagDst == qOpB[i].src.tag;
            candidate[i] = (i < insertIndex)
                && (qAvailA[i] || wakeA[i])
                && (qAvailB[i] || wakeB[i])
                && !(qOp[i] != iqPkg::OP_MUL && reservedWb[0]);
        end
    end

    priorityEncoder #(
        .WIDTH(SIZE)
    ) i_selEnc (
        .req   (candidate),
        .idx   (selIdx),
        .found (selFound)
    );

    // Keep everything up to the last entry that survives the flush
    always_comb begin
        flushIndex = '0;
        for (int i = 0; i < SIZE; i++) begin
            if (i < insertIndex && !iqPkg::isYounger(qSqn[i], flushSqn))
                flushIndex = (IDX_BITS + 1)'(i + 1);
        end
    end

    always_ff @(posedge clk) begin
        logic [IDX_BITS:0] nextIndex;

        for (int i = 0; i < SIZE; i++) begin
            qAvailA[i] <= qAvailA[i] | wakeA[i];
            qAvailB[i] <= qAvailB[i] | wakeB[i];
        end
        reservedWb <= reservedWb >> 1;

        if (rst) begin
            insertIndex <= '0;
            reservedWb <= '0;
            issValid <= 1'b0;
        end else if (flush) begin
            insertIndex <= flushIndex;
            issValid <= 1'b0;
        end else begin
            nextIndex = insertIndex;
            issValid <= selFound;

            if (selFound) begin
                issOp <= qOp[selIdx];
                issSqn <= qSqn[selIdx];
                issTagDst <= qTagDst[selIdx];
                issTagA <= qTagA[selIdx];
                issOpB <= qOpB[selIdx];
                issImmB <= qImmB[selIdx];

                // Multiply claims the bus slot an ALU op issued two cycles later would use
                if (qOp[selIdx] == iqPkg::OP_MUL)
                    reservedWb <= (reservedWb >> 1) | MUL_SLOT;

                nextIndex = nextIndex - 1'b1;

                // Compact younger entries into the freed slot
                for (int i = 0; i < SIZE - 1; i++) begin
                    if (i >= selIdx) begin
                        qOp[i] <= qOp[i+1];
                        qSqn[i] <= qSqn[i+1];
                        qTagDst[i] <= qTagDst[i+1];
                        qTagA[i] <= qTagA[i+1];
                        qOpB[i] <= qOpB[i+1];
                        qImmB[i] <= qImmB[i+1];
                        qAvailA[i] <= qAvailA[i+1] | wakeA[i+1];
                        qAvailB[i] <= qAvailB[i+1] | wakeB[i+1];
                    end
                end
            end

            if (enqValid) begin
                qOp[nextIndex[IDX_BITS-1:0]] <= dispOp;
                qSqn[nextIndex[IDX_BITS-1:0]] <= dispSqn;
                qTagDst[nextIndex[IDX_BITS-1:0]] <= dispTagDst;
                qTagA[nextIndex[IDX_BITS-1:0]] <= dispTagA;
                qOpB[nextIndex[IDX_BITS-1:0]] <= dispOpB;
                qImmB[nextIndex[IDX_BITS-1:0]] <= dispImmB;
                qAvailA[nextIndex[IDX_BITS-1:0]] <= enqAvailA;
                qAvailB[nextIndex[IDX_BITS-1:0]] <= enqAvailB;
                nextIndex = nextIndex + 1'b1;
            end

            insertIndex <= nextIndex;
        end
    end

endmodule

`default_nettype wire

//--- issueQueue/priorityEncoder.sv
`timescale 1ns/1ps
`default_nettype none

module priorityEncoder #(
    parameter int WIDTH = 8
) (
    input  wire [WIDTH-1:0]                       req,
    output logic [(WIDTH > 1 ? $clog2(WIDTH) : 1)-1:0] idx,
    output logic                                  found
);

    localparam int IDX_BITS = (WIDTH > 1) ? $clog2(WIDTH) : 1;

    // Scan downwards so the lowest set bit wins
    always_comb begin
        idx = '0;
        found = 1'b0;
        for (int i = WIDTH - 1; i >= 0; i--) begin
            if (req[i]) begin
                idx = IDX_BITS'(i);
                found = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- common/iqPkg.sv
`default_nettype none

`include "iq_cfg.svh"

package iqPkg;

    typedef logic [`IQ_TAG_BITS-1:0] tag_t;

    typedef logic [`IQ_SQN_BITS-1:0] sqn_t;

    typedef enum logic [2:0] {
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_XOR,
        OP_SHL,
        OP_MUL
    } aluOp_t;

    // Operand B word, immB selects immediate or register reading
    typedef union packed {
        logic [`IQ_DATA_BITS-1:0] imm;
        struct packed {
            logic [`IQ_DATA_BITS-`IQ_TAG_BITS-1:0] pad;
            tag_t tag;
        } src;
    } opB_t;

    // True when sqn is younger than pivot, wrap-around safe
    function automatic logic isYounger(sqn_t sqn, sqn_t pivot);
        return $signed(sqn - pivot) > 0;
    endfunction

endpackage

`default_nettype wire

//--- common/iq_cfg.svh
`ifndef IQ_CFG_SVH
`define IQ_CFG_SVH

// Number of issue queue entries
`define IQ_SIZE 8

// Physical register tag width, tag 0 is the zero register
`define IQ_TAG_BITS 5

// Operand and result width
`define IQ_DATA_BITS 32

// Sequence number width, compared by wrapped signed difference
`define IQ_SQN_BITS 6

// Cycles from multiply issue to its result on the bus
`define IQ_MUL_LAT 3

`endif
